//--- src/mmix_pkg.sv
package mmix_pkg;

	// operations the dispatch stage hands on to the execute units
	// incrl and incgamma never come from memory, they are inserted here
	typedef enum logic [4:0] {
		trap,
		add,
		addu,
		sub,
		subu,
		cmp,
		cmpu,
		shl,
		shr,
		br,
		pbr,
		cset,
		ld,
		st,
		pst,
		logic_op,
		set,
		jmp,
		get,
		put,
		noop,
		incrl,
		incgamma
	} internal_op_t;

	// what an operand spec points at
	typedef enum logic [1:0] {
		spec_none,
		spec_imm,
		spec_global,
		spec_local
	} spec_kind_t;

	// value is the immediate, the global number or the ring slot
	typedef struct packed {
		spec_kind_t kind;
		logic [63:0] value;
	} operand_spec_t;

	// bit positions of the per-opcode operand flags
	localparam int fb_z_imm = 0;
	localparam int fb_z_reg = 1;
	localparam int fb_y_imm = 2;
	localparam int fb_y_reg = 3;
	localparam int fb_x_src = 4;
	localparam int fb_x_dest = 5;
	localparam int fb_rel_addr = 6;

	// special registers that GET answers directly
	localparam logic [7:0] rO = 8'd10;
	localparam logic [7:0] rS = 8'd11;
	localparam logic [7:0] rG = 8'd19;
	localparam logic [7:0] rL = 8'd20;

	// opcode bytes that need their own handling
	localparam logic [7:0] op_jmp = 8'hf0;
	localparam logic [7:0] op_trip = 8'hff;

	// one decoded instruction
	typedef struct packed {
		logic [7:0] opcode;
		logic [7:0] xx;
		logic [7:0] yy;
		logic [7:0] zz;
		internal_op_t op;
		// Z is an immediate
		logic z_imm;
		// Z names a source register
		logic z_reg;
		logic y_imm;
		logic y_reg;
		// X is read as a source
		logic x_src;
		// X is written
		logic x_dest;
		// YZ or XYZ is a relative offset
		logic rel_addr;
	} decode_t;

endpackage

//--- src/stack_if.sv
interface stack_if;

	// register stack pointers
	// l and g count registers, o and s are octabyte indexes
	logic [7:0] l;
	logic [63:0] o;
	logic [63:0] s;
	logic [7:0] g;

	// values the dispatch logic wants after this instruction
	logic [7:0] next_l;
	logic [63:0] next_o;
	logic [63:0] next_s;
	// next values are taken only when commit is high
	logic commit;

	// pointer registers
	modport owner (output l, o, s, g, input next_l, next_o, next_s, commit);

	// destination renaming, decides the next pointers
	modport user (input l, o, s, g, output next_l, next_o, next_s, commit);

	// source operand mapping only needs the local window
	modport reader (input l, o, g);

endinterface

//--- src/op_class_decode.sv
module op_class_decode import mmix_pkg::*; (
	input logic [31:0] inst,
	input logic loc_user,
	output decode_t dec
);

	// flag masks built from the shared bit positions
	localparam logic [6:0] m_z_imm = 7'b1 << fb_z_imm;
	localparam logic [6:0] m_z_reg = 7'b1 << fb_z_reg;
	localparam logic [6:0] m_y_imm = 7'b1 << fb_y_imm;
	localparam logic [6:0] m_y_reg = 7'b1 << fb_y_reg;
	localparam logic [6:0] m_x_src = 7'b1 << fb_x_src;
	localparam logic [6:0] m_x_dest = 7'b1 << fb_x_dest;
	localparam logic [6:0] m_rel = 7'b1 << fb_rel_addr;

	logic [7:0] opcode;
	logic [6:0] m_z;
	logic [6:0] flags;
	internal_op_t op;

	assign opcode = inst[31:24];

	// odd opcode means the immediate form
	assign m_z = opcode[0] ? m_z_imm : m_z_reg;

	always_comb begin
		// trap covers floating, mul/div, byte diff, mux and the left-out stack ops
		op = trap;
		flags = m_y_reg | m_z_reg;
		case (opcode[7:3])
		5'h04: begin
			// ADD ADDU SUB SUBU
			case (opcode[2:1])
			2'd0: op = add;
			2'd1: op = addu;
			2'd2: op = sub;
			default: op = subu;
			endcase
			flags = m_x_dest | m_y_reg | m_z;
		end
		5'h05: begin
			// scaled adds 2ADDU to 16ADDU
			op = addu;
			flags = m_x_dest | m_y_reg | m_z;
		end
		5'h06: begin
			case (opcode[2:1])
			2'd0: op = cmp;
			2'd1: op = cmpu;
			2'd2: op = sub;
			default: op = subu;
			endcase
			// NEG takes Y as a small immediate
			flags = m_x_dest | (opcode[2] ? m_y_imm : m_y_reg) | m_z;
		end
		5'h07: begin
			op = opcode[2] ? shr : shl;
			flags = m_x_dest | m_y_reg | m_z;
		end
		5'h08, 5'h09: begin
			op = br;
			flags = m_x_src | m_rel;
		end
		5'h0a, 5'h0b: begin
			op = pbr;
			flags = m_x_src | m_rel;
		end
		5'h0c, 5'h0d: begin
			op = cset;
			flags = m_x_src | m_x_dest | m_y_reg | m_z;
		end
		5'h0e, 5'h0f: begin
			// ZS is a conditional set whose other value is zero, so X is not read
			op = cset;
			flags = m_x_dest | m_y_reg | m_z;
		end
		5'h10, 5'h11, 5'h12: begin
			op = ld;
			flags = m_x_dest | m_y_reg | m_z;
		end
		5'h13: begin
			// preload and GO hints
			op = noop;
			flags = m_y_reg | m_z;
		end
		5'h14, 5'h15, 5'h16: begin
			// STO and STOU write whole octas, the rest are partial
			op = (opcode[7:2] == 6'h2b) ? st : pst;
			flags = m_x_src | m_y_reg | m_z;
		end
		5'h17: begin
			// syncs and PREST, PUSHGO left out
			op = (opcode[2:1] == 2'd3) ? trap : noop;
			flags = m_y_reg | m_z;
		end
		5'h18, 5'h19: begin
			op = logic_op;
			flags = m_x_dest | m_y_reg | m_z;
		end
		5'h1c: begin
			// SETH family writes X, INCH family also reads it
			op = opcode[2] ? addu : set;
			flags = opcode[2] ? (m_x_src | m_x_dest) : m_x_dest;
		end
		5'h1d: begin
			// ORH and ANDNH family
			op = logic_op;
			flags = m_x_src | m_x_dest;
		end
		5'h1e: begin
			case (opcode[2:1])
			2'd0: begin
				op = jmp;
				flags = m_rel;
			end
			2'd2: begin
				// GETA
				op = set;
				flags = m_x_dest | m_rel;
			end
			2'd3: begin
				op = put;
				flags = m_z;
			end
			default: op = trap;
			endcase
		end
		5'h1f: begin
			case (opcode[2:0])
			3'd4, 3'd5: begin
				// SYNC and SWYM
				op = noop;
				flags = '0;
			end
			3'd6: begin
				op = get;
				flags = m_x_dest;
			end
			default: op = trap;
			endcase
		end
		default: begin
			op = trap;
			flags = m_y_reg | m_z_reg;
		end
		endcase
		// TRIP from user space is ignored
		if (loc_user && opcode == op_trip) begin
			op = noop;
			flags = '0;
		end
	end

	always_comb begin
		dec.opcode = opcode;
		dec.xx = inst[23:16];
		dec.yy = inst[15:8];
		dec.zz = inst[7:0];
		dec.op = op;
		dec.z_imm = flags[fb_z_imm];
		dec.z_reg = flags[fb_z_reg];
		dec.y_imm = flags[fb_y_imm];
		dec.y_reg = flags[fb_y_reg];
		dec.x_src = flags[fb_x_src];
		dec.x_dest = flags[fb_x_dest];
		dec.rel_addr = flags[fb_rel_addr];
	end

endmodule

//--- src/operand_decode.sv
module operand_decode import mmix_pkg::*; #(
	parameter int ring_size = 256
) (
	input decode_t dec,
	input logic [63:0] loc,
	stack_if.reader stk,
	output operand_spec_t y,
	output operand_spec_t z
);

	localparam logic [63:0] ring_mask = 64'(ring_size - 1);

	logic is_jmp;
	logic wyde_form;
	logic [15:0] yz;
	logic [63:0] rel_offset;
	logic [63:0] wyde;

	// globals keep their number, locals go to a ring slot
	// a marginal register between L and G reads as zero
	function automatic operand_spec_t map_reg(input logic [7:0] r, input logic [7:0] l,
			input logic [7:0] g, input logic [63:0] o);
		operand_spec_t spec;
		if (r >= g)
			spec = '{spec_global, {56'd0, r}};
		else if (r < l)
			spec = '{spec_local, (o + 64'(r)) & ring_mask};
		else
			spec = '{spec_imm, 64'd0};
		return spec;
	endfunction

	assign is_jmp = ({dec.opcode[7:1], 1'b0} == op_jmp);
	assign wyde_form = (dec.opcode[7:4] == 4'he);
	assign yz = {dec.yy, dec.zz};

	// backward forms have opcode bit 0 set, offsets count tetras
	assign rel_offset = is_jmp ? {{38{dec.opcode[0]}}, dec.xx, yz, 2'b00}
		: {{46{dec.opcode[0]}}, yz, 2'b00};

	// low two opcode bits pick the wyde, H first
	always_comb begin
		case (dec.opcode[1:0])
		2'd0: wyde = {yz, 48'd0};
		2'd1: wyde = {16'd0, yz, 32'd0};
		2'd2: wyde = {32'd0, yz, 16'd0};
		default: wyde = {48'd0, yz};
		endcase
	end

	always_comb begin
		if (dec.rel_addr) begin
			// y carries the fall-through, z the target
			y = '{spec_imm, loc + 64'd4};
			z = '{spec_imm, loc + rel_offset};
		end else begin
			if (wyde_form)
				z = '{spec_imm, wyde};
			else if (dec.z_imm)
				z = '{spec_imm, {56'd0, dec.zz}};
			else if (dec.z_reg)
				z = map_reg(dec.zz, stk.l, stk.g, stk.o);
			else
				z = '{spec_none, 64'd0};

			// INCH and ORH style ops read X through y
			if (wyde_form && dec.x_src)
				y = map_reg(dec.xx, stk.l, stk.g, stk.o);
			else if (dec.y_imm)
				y = '{spec_imm, {56'd0, dec.yy}};
			else if (dec.y_reg)
				y = map_reg(dec.yy, stk.l, stk.g, stk.o);
			else
				y = '{spec_none, 64'd0};
		end
	end

endmodule

//--- src/dest_rename.sv
module dest_rename import mmix_pkg::*; #(
	parameter int ring_size = 256
) (
	input decode_t dec,
	input operand_spec_t y_in,
	input operand_spec_t z_in,
	input logic loc_user,
	stack_if.user stk,
	output internal_op_t op,
	output operand_spec_t y,
	output operand_spec_t z,
	output operand_spec_t x,
	output logic ren_x,
	output logic mem_x,
	output logic interim,
	output logic bad_inst,
	output logic priv,
	output logic hold
);

	localparam logic [63:0] ring_mask = 64'(ring_size - 1);

	logic marginal;
	logic ring_full;

	// destination falls between L and G
	assign marginal = dec.x_dest && (dec.xx >= stk.l) && (dec.xx < stk.g);

	// one more local would run into gamma
	assign ring_full = (((stk.s - stk.o - 64'(stk.l) - 64'd1) & ring_mask) == 64'd0);

	// only inserted commands move the pointers
	assign stk.commit = marginal;

	always_comb begin
		op = dec.op;
		y = y_in;
		z = z_in;
		x = '{spec_none, 64'd0};
		ren_x = 1'b0;
		mem_x = 1'b0;
		interim = 1'b0;
		bad_inst = 1'b0;
		priv = 1'b0;
		hold = 1'b0;
		stk.next_l = stk.l;
		stk.next_o = stk.o;
		stk.next_s = stk.s;

		if (marginal) begin
			if (ring_full) begin
				// spill slot gamma to memory at S*8
				op = incgamma;
				x = '{spec_local, stk.s & ring_mask};
				y = '{spec_imm, {stk.s[60:0], 3'b000}};
				mem_x = 1'b1;
				stk.next_s = stk.s + 64'd1;
			end else begin
				// grow the local window by one cleared register
				op = incrl;
				x = '{spec_local, (stk.o + 64'(stk.l)) & ring_mask};
				y = '{spec_none, 64'd0};
				ren_x = 1'b1;
				stk.next_l = stk.l + 8'd1;
			end
			z = '{spec_none, 64'd0};
			// the original instruction comes back afterwards
			interim = 1'b1;
			hold = 1'b1;
		end else begin
			if (dec.x_dest) begin
				if (dec.xx >= stk.g) begin
					ren_x = 1'b1;
					x = '{spec_global, {56'd0, dec.xx}};
				end else if (dec.xx < stk.l) begin
					ren_x = 1'b1;
					x = '{spec_local, (stk.o + 64'(dec.xx)) & ring_mask};
				end
			end

			case (dec.op)
			pst: mem_x = 1'b1;
			put: begin
				// rN rO rS are read only, rC..rV need kernel mode
				if (dec.yy != 8'd0 || dec.xx >= 8'd32 || (dec.xx >= 8'd9 && dec.xx <= 8'd11)) begin
					bad_inst = 1'b1;
					op = noop;
				end else if (dec.xx >= 8'd8 && dec.xx <= 8'd18 && loc_user) begin
					priv = 1'b1;
					op = noop;
				end else begin
					ren_x = 1'b1;
					x = '{spec_global, {56'd0, dec.xx}};
				end
			end
			get: begin
				if (dec.yy != 8'd0 || dec.zz >= 8'd32) begin
					bad_inst = 1'b1;
					op = noop;
				end else begin
					// stack pointers are held here, not in the register file
					case (dec.zz)
					rO: z = '{spec_imm, {stk.o[60:0], 3'b000}};
					rS: z = '{spec_imm, {stk.s[60:0], 3'b000}};
					rG: z = '{spec_imm, {56'd0, stk.g}};
					rL: z = '{spec_imm, {56'd0, stk.l}};
					default: z = '{spec_global, {56'd0, dec.zz}};
					endcase
				end
			end
			default: ;
			endcase
		end
	end

endmodule

//--- src/stack_regs.sv
module stack_regs import mmix_pkg::*; #(
	parameter int ring_size = 256,
	parameter int global_reset = 32
) (
	input logic clk,
	input logic rst_n,
	input logic inst_valid,
	stack_if.owner stk,
	input internal_op_t op_in,
	input operand_spec_t y_in,
	input operand_spec_t z_in,
	input operand_spec_t x_in,
	input logic ren_x,
	input logic mem_x,
	input logic interim,
	input logic bad_inst,
	input logic priv,
	input logic hold,
	output logic out_valid,
	output internal_op_t op_q,
	output operand_spec_t y_q,
	output operand_spec_t z_q,
	output operand_spec_t x_q,
	output logic ren_x_q,
	output logic mem_x_q,
	output logic interim_q,
	output logic bad_inst_q,
	output logic priv_q,
	output logic hold_q
);

	localparam logic [63:0] ring_mask = 64'(ring_size - 1);

	// local slot numbers leave on ring width
	function automatic operand_spec_t ring_wrap(input operand_spec_t spec);
		operand_spec_t res;
		res = spec;
		if (spec.kind == spec_local)
			res.value = spec.value & ring_mask;
		return res;
	endfunction

	// rG cannot be written, so it stays at its reset value
	assign stk.g = 8'(global_reset);

	// pointers move with the same edge that registers the result
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stk.l <= 8'd0;
			stk.o <= 64'd0;
			stk.s <= 64'd0;
		end else if (inst_valid && stk.commit) begin
			stk.l <= stk.next_l;
			stk.o <= stk.next_o;
			stk.s <= stk.next_s;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			ren_x_q <= 1'b0;
			mem_x_q <= 1'b0;
			interim_q <= 1'b0;
			bad_inst_q <= 1'b0;
			priv_q <= 1'b0;
			hold_q <= 1'b0;
		end else begin
			// one pulse per accepted instruction
			out_valid <= inst_valid;
			if (inst_valid) begin
				ren_x_q <= ren_x;
				mem_x_q <= mem_x;
				interim_q <= interim;
				bad_inst_q <= bad_inst;
				priv_q <= priv;
				// hold stays up until the next instruction arrives
				hold_q <= hold;
			end
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (inst_valid) begin
			op_q <= op_in;
			y_q <= ring_wrap(y_in);
			z_q <= ring_wrap(z_in);
			x_q <= ring_wrap(x_in);
		end
	end

endmodule

//--- src/mmix_dispatch.sv
module mmix_dispatch import mmix_pkg::*; #(
	parameter int ring_size = 256,
	parameter int global_reset = 32
) (
	input logic clk,
	input logic rst_n,
	input logic inst_valid,
	input logic [31:0] inst,
	input logic [63:0] loc,
	output logic out_valid,
	output internal_op_t out_op,
	output spec_kind_t out_y_kind,
	output logic [63:0] out_y_val,
	output spec_kind_t out_z_kind,
	output logic [63:0] out_z_val,
	output spec_kind_t out_x_kind,
	output logic [63:0] out_x_val,
	output logic ren_x,
	output logic mem_x,
	output logic interim,
	output logic bad_inst,
	output logic priv,
	output logic hold,
	output logic [7:0] l_reg,
	output logic [63:0] o_reg,
	output logic [63:0] s_reg
);

	stack_if stk ();

	logic loc_user;
	decode_t dec;
	operand_spec_t y_dec;
	operand_spec_t z_dec;
	internal_op_t op_ren;
	operand_spec_t y_ren;
	operand_spec_t z_ren;
	operand_spec_t x_ren;
	logic ren_x_c;
	logic mem_x_c;
	logic interim_c;
	logic bad_inst_c;
	logic priv_c;
	logic hold_c;
	operand_spec_t y_q;
	operand_spec_t z_q;
	operand_spec_t x_q;

	// negative addresses are kernel space
	assign loc_user = ~loc[63];

	op_class_decode u_class (
		.inst     (inst),
		.loc_user (loc_user),
		.dec      (dec)
	);

	operand_decode #(
		.ring_size (ring_size)
	) u_operand (
		.dec (dec),
		.loc (loc),
		.stk (stk.reader),
		.y   (y_dec),
		.z   (z_dec)
	);

	dest_rename #(
		.ring_size (ring_size)
	) u_rename (
		.dec      (dec),
		.y_in     (y_dec),
		.z_in     (z_dec),
		.loc_user (loc_user),
		.stk      (stk.user),
		.op       (op_ren),
		.y        (y_ren),
		.z        (z_ren),
		.x        (x_ren),
		.ren_x    (ren_x_c),
		.mem_x    (mem_x_c),
		.interim  (interim_c),
		.bad_inst (bad_inst_c),
		.priv     (priv_c),
		.hold     (hold_c)
	);

	stack_regs #(
		.ring_size    (ring_size),
		.global_reset (global_reset)
	) u_stack (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.stk        (stk.owner),
		.op_in      (op_ren),
		.y_in       (y_ren),
		.z_in       (z_ren),
		.x_in       (x_ren),
		.ren_x      (ren_x_c),
		.mem_x      (mem_x_c),
		.interim    (interim_c),
		.bad_inst   (bad_inst_c),
		.priv       (priv_c),
		.hold       (hold_c),
		.out_valid  (out_valid),
		.op_q       (out_op),
		.y_q        (y_q),
		.z_q        (z_q),
		.x_q        (x_q),
		.ren_x_q    (ren_x),
		.mem_x_q    (mem_x),
		.interim_q  (interim),
		.bad_inst_q (bad_inst),
		.priv_q     (priv),
		.hold_q     (hold)
	);

	// flatten the specs onto plain ports
	assign out_y_kind = y_q.kind;
	assign out_y_val = y_q.value;
	assign out_z_kind = z_q.kind;
	assign out_z_val = z_q.value;
	assign out_x_kind = x_q.kind;
	assign out_x_val = x_q.value;

	assign l_reg = stk.l;
	assign o_reg = stk.o;
	assign s_reg = stk.s;

endmodule

//--- sim/tb_mmix_dispatch.sv
module tb_mmix_dispatch import mmix_pkg::*;;

	localparam int n_margin = 10;
	localparam int n_arith = 40;
	localparam int n_branch = 8;
	localparam int n_jump = 4;
	// margin, arith with idles, wyde forms, branches, jumps, traps, put, get, spare idles
	localparam int stim_cycles = n_margin + 2 * n_arith + 8 + n_branch + n_jump + 5 + 8 + 7 + 4;
	localparam int cycle_limit = 2 * stim_cycles + 10;
	localparam logic [63:0] mask = 64'd7;
	localparam logic [7:0] g_val = 8'd32;

	logic clk;
	logic rst_n;
	logic inst_valid;
	logic [31:0] inst;
	logic [63:0] loc;
	logic out_valid;
	internal_op_t out_op;
	spec_kind_t out_y_kind;
	logic [63:0] out_y_val;
	spec_kind_t out_z_kind;
	logic [63:0] out_z_val;
	spec_kind_t out_x_kind;
	logic [63:0] out_x_val;
	logic ren_x;
	logic mem_x;
	logic interim;
	logic bad_inst;
	logic priv;
	logic hold;
	logic [7:0] l_reg;
	logic [63:0] o_reg;
	logic [63:0] s_reg;

	// reference model of the register stack
	logic [7:0] m_l;
	logic [63:0] m_o;
	logic [63:0] m_s;

	// expected dispatch result of the instruction in flight
	internal_op_t e_op;
	operand_spec_t e_y;
	operand_spec_t e_z;
	operand_spec_t e_x;
	logic e_ren;
	logic e_mem;
	logic e_interim;
	logic e_bad;
	logic e_priv;
	logic e_hold;
	logic saw_gamma;

	logic [63:0] rng;
	int errors;
	int checks;
	int cycles;

	mmix_dispatch #(
		.ring_size    (8),
		.global_reset (32)
	) UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.loc        (loc),
		.out_valid  (out_valid),
		.out_op     (out_op),
		.out_y_kind (out_y_kind),
		.out_y_val  (out_y_val),
		.out_z_kind (out_z_kind),
		.out_z_val  (out_z_val),
		.out_x_kind (out_x_kind),
		.out_x_val  (out_x_val),
		.ren_x      (ren_x),
		.mem_x      (mem_x),
		.interim    (interim),
		.bad_inst   (bad_inst),
		.priv       (priv),
		.hold       (hold),
		.l_reg      (l_reg),
		.o_reg      (o_reg),
		.s_reg      (s_reg)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// run limit, counts from time zero so reset is included
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	function logic [63:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 7);
		rng = rng ^ (rng << 17);
		return rng;
	endfunction

	function operand_spec_t mk_spec(input spec_kind_t k, input logic [63:0] v);
		operand_spec_t res;
		res.kind = k;
		res.value = v;
		return res;
	endfunction

	// source register as the model sees it
	function operand_spec_t reg_spec(input logic [7:0] r);
		if (r >= g_val)
			return mk_spec(spec_global, 64'(r));
		else if (r < m_l)
			return mk_spec(spec_local, (m_o + 64'(r)) & mask);
		// marginal source reads as zero
		return mk_spec(spec_imm, 64'd0);
	endfunction

	// register that is either global or inside the local window, never marginal
	function logic [7:0] pick_reg();
		logic [63:0] r;
		r = next_rand();
		if (r[0] || m_l == 8'd0)
			return 8'(32 + r[15:8] % 224);
		return 8'(r[15:8] % m_l);
	endfunction

	task check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("error %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task clear_expect();
		e_op = noop;
		e_y = mk_spec(spec_none, 64'd0);
		e_z = mk_spec(spec_none, 64'd0);
		e_x = mk_spec(spec_none, 64'd0);
		e_ren = 1'b0;
		e_mem = 1'b0;
		e_interim = 1'b0;
		e_bad = 1'b0;
		e_priv = 1'b0;
		e_hold = 1'b0;
	endtask

	// destination renaming, or an inserted command when X is marginal
	task dest_rule(input logic [7:0] xx);
		if (xx >= g_val) begin
			e_ren = 1'b1;
			e_x = mk_spec(spec_global, 64'(xx));
		end else if (xx < m_l) begin
			e_ren = 1'b1;
			e_x = mk_spec(spec_local, (m_o + 64'(xx)) & mask);
		end else begin
			e_interim = 1'b1;
			e_hold = 1'b1;
			e_z = mk_spec(spec_none, 64'd0);
			if (((m_s - m_o - 64'(m_l) - 64'd1) & mask) == 64'd0) begin
				// ring full, spill gamma to memory
				e_op = incgamma;
				e_x = mk_spec(spec_local, m_s & mask);
				e_y = mk_spec(spec_imm, m_s << 3);
				e_mem = 1'b1;
				m_s = m_s + 64'd1;
			end else begin
				e_op = incrl;
				e_x = mk_spec(spec_local, (m_o + 64'(m_l)) & mask);
				e_y = mk_spec(spec_none, 64'd0);
				e_ren = 1'b1;
				m_l = m_l + 8'd1;
			end
		end
	endtask

	// drive one instruction and compare the registered result one edge later
	task issue(input logic [31:0] word, input logic [63:0] where);
		inst_valid = 1'b1;
		inst = word;
		loc = where;
		@(posedge clk);
		#1;
		inst_valid = 1'b0;
		check("out_valid", 64'(out_valid), 64'd1);
		check("out_op", 64'(out_op), 64'(e_op));
		check("out_y_kind", 64'(out_y_kind), 64'(e_y.kind));
		check("out_y_val", out_y_val, e_y.value);
		check("out_z_kind", 64'(out_z_kind), 64'(e_z.kind));
		check("out_z_val", out_z_val, e_z.value);
		check("out_x_kind", 64'(out_x_kind), 64'(e_x.kind));
		check("out_x_val", out_x_val, e_x.value);
		check("ren_x", 64'(ren_x), 64'(e_ren));
		check("mem_x", 64'(mem_x), 64'(e_mem));
		check("interim", 64'(interim), 64'(e_interim));
		check("bad_inst", 64'(bad_inst), 64'(e_bad));
		check("priv", 64'(priv), 64'(e_priv));
		check("hold", 64'(hold), 64'(e_hold));
		check("l_reg", 64'(l_reg), 64'(m_l));
		check("o_reg", o_reg, m_o);
		check("s_reg", s_reg, m_s);
	endtask

	// no instruction, so no output pulse
	task idle();
		@(posedge clk);
		#1;
		check("out_valid", 64'(out_valid), 64'd0);
	endtask

	// ADD $7,$40,$41 presented again while the DUT holds
	task margin_dest();
		int i;
		logic done;
		done = 1'b0;
		saw_gamma = 1'b0;
		for (i = 0; i < n_margin && !done; i++) begin
			clear_expect();
			e_op = add;
			e_y = reg_spec(8'd40);
			e_z = reg_spec(8'd41);
			dest_rule(8'd7);
			issue({8'h20, 8'd7, 8'd40, 8'd41}, 64'h100);
			if (out_op == incgamma && mem_x)
				saw_gamma = 1'b1;
			if (!hold)
				done = 1'b1;
		end
		if (!done) begin
			$display("marginal destination was never dispatched");
			errors++;
		end
		if (!saw_gamma) begin
			$display("full ring never produced an incgamma");
			errors++;
		end
	endtask

	task arith_ops();
		int i;
		logic [63:0] r;
		logic [7:0] opc;
		logic [7:0] xx;
		logic [7:0] yy;
		logic [7:0] zz;
		for (i = 0; i < n_arith; i++) begin
			r = next_rand();
			clear_expect();
			case (r[2:0])
			3'd0: opc = 8'h20;
			3'd1: opc = 8'h22;
			3'd2: opc = 8'h24;
			3'd3: opc = 8'h26;
			3'd4: opc = 8'hc0;
			3'd5: opc = 8'hc4;
			3'd6: opc = 8'hc8;
			default: opc = 8'hcc;
			endcase
			case (r[2:0])
			3'd0: e_op = add;
			3'd1: e_op = addu;
			3'd2: e_op = sub;
			3'd3: e_op = subu;
			default: e_op = logic_op;
			endcase
			xx = pick_reg();
			yy = pick_reg();
			e_y = reg_spec(yy);
			// odd opcode takes Z as an immediate byte
			if (r[3]) begin
				opc = opc | 8'h01;
				zz = r[47:40];
				e_z = mk_spec(spec_imm, 64'(zz));
			end else begin
				zz = pick_reg();
				e_z = reg_spec(zz);
			end
			dest_rule(xx);
			issue({opc, xx, yy, zz}, r);
			if (r[4])
				idle();
		end
	endtask

	// SETH..SETL then INCH..INCL, wyde picked by the low opcode bits
	task wyde_forms();
		int w;
		logic [63:0] r;
		logic [7:0] xx;
		logic [15:0] yz;
		for (w = 0; w < 8; w++) begin
			r = next_rand();
			clear_expect();
			xx = pick_reg();
			yz = r[31:16];
			e_z = mk_spec(spec_imm, 64'(yz) << (16 * (3 - (w % 4))));
			if (w < 4) begin
				e_op = set;
			end else begin
				e_op = addu;
				e_y = reg_spec(xx);
			end
			dest_rule(xx);
			issue({8'he0 | 8'(w), xx, yz}, 64'h2000);
		end
	endtask

	task branch_targets();
		int i;
		logic [63:0] r;
		logic [63:0] where;
		logic [7:0] xx;
		logic [23:0] off;
		for (i = 0; i < n_branch + n_jump; i++) begin
			r = next_rand();
			where = next_rand();
			xx = pick_reg();
			off = r[39:16];
			clear_expect();
			e_y = mk_spec(spec_imm, where + 64'd4);
			if (i < n_branch) begin
				// BZ or PBZ, 16 bit offset, bit 0 gives the backward form
				e_op = r[0] ? pbr : br;
				e_z = mk_spec(spec_imm, where + (64'(off[15:0]) << 2)
					- (r[1] ? 64'h40000 : 64'd0));
				issue({(r[0] ? 8'h52 : 8'h42) | 8'(r[1]), xx, off[15:0]}, where);
			end else begin
				e_op = jmp;
				e_z = mk_spec(spec_imm, where + (64'(off) << 2)
					- (r[1] ? 64'h4000000 : 64'd0));
				issue({8'hf0 | 8'(r[1]), off}, where);
			end
		end
	endtask

	// FMUL, MUL, DIV and MUX are not executed here
	task unsupported_ops();
		int i;
		logic [7:0] opc;
		logic [7:0] yy;
		logic [7:0] zz;
		for (i = 0; i < 4; i++) begin
			case (i)
			0: opc = 8'h10;
			1: opc = 8'h18;
			2: opc = 8'h1c;
			default: opc = 8'hd8;
			endcase
			yy = pick_reg();
			zz = pick_reg();
			clear_expect();
			e_op = trap;
			e_y = reg_spec(yy);
			e_z = reg_spec(zz);
			issue({opc, 8'd1, yy, zz}, 64'h3000);
		end
		// user space TRIP does nothing
		clear_expect();
		issue({8'hff, 8'd0, 8'd5, 8'd6}, 64'h3004);
	endtask

	// PUTI, kernel space when loc bit 63 is set
	task put_special(input logic [7:0] xx, input logic [7:0] yy, input logic kernel);
		clear_expect();
		e_z = mk_spec(spec_imm, 64'd5);
		if (yy != 8'd0 || xx >= 8'd32 || (xx >= 8'd9 && xx <= 8'd11)) begin
			e_bad = 1'b1;
		end else if (xx >= 8'd8 && xx <= 8'd18 && !kernel) begin
			e_priv = 1'b1;
		end else begin
			e_op = put;
			e_ren = 1'b1;
			e_x = mk_spec(spec_global, 64'(xx));
		end
		issue({8'hf7, xx, yy, 8'd5}, kernel ? 64'h8000_0000_0000_4000 : 64'h4000);
	endtask

	// GET answers rO=10, rS=11, rG=19 and rL=20 from the stack pointers
	task get_special(input logic [7:0] xx, input logic [7:0] yy, input logic [7:0] zz);
		clear_expect();
		e_op = get;
		if (yy != 8'd0 || zz >= 8'd32) begin
			e_bad = 1'b1;
			e_op = noop;
		end else begin
			case (zz)
			8'd10: e_z = mk_spec(spec_imm, m_o << 3);
			8'd11: e_z = mk_spec(spec_imm, m_s << 3);
			8'd19: e_z = mk_spec(spec_imm, 64'(g_val));
			8'd20: e_z = mk_spec(spec_imm, 64'(m_l));
			default: e_z = mk_spec(spec_global, 64'(zz));
			endcase
		end
		dest_rule(xx);
		issue({8'hfe, xx, yy, zz}, 64'h5000);
	endtask

	initial begin
		rng = 64'd59400;
		errors = 0;
		checks = 0;
		cycles = 0;
		rst_n = 1'b0;
		inst_valid = 1'b0;
		inst = 32'd0;
		loc = 64'd0;
		m_l = 8'd0;
		m_o = 64'd0;
		m_s = 64'd0;
		clear_expect();
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check("out_valid", 64'(out_valid), 64'd0);
		check("hold", 64'(hold), 64'd0);
		check("ren_x", 64'(ren_x), 64'd0);
		check("mem_x", 64'(mem_x), 64'd0);
		check("interim", 64'(interim), 64'd0);
		check("l_reg", 64'(l_reg), 64'd0);
		check("o_reg", o_reg, 64'd0);
		check("s_reg", s_reg, 64'd0);
		idle();

		margin_dest();
		idle();
		arith_ops();
		wyde_forms();
		branch_targets();
		unsupported_ops();
		idle();

		put_special(8'd0, 8'd1, 1'b0);
		put_special(8'd40, 8'd0, 1'b0);
		put_special(8'd10, 8'd0, 1'b1);
		put_special(8'd12, 8'd0, 1'b0);
		put_special(8'd18, 8'd0, 1'b0);
		put_special(8'd12, 8'd0, 1'b1);
		put_special(8'd20, 8'd0, 1'b0);
		put_special(8'd3, 8'd0, 1'b0);

		get_special(8'd3, 8'd0, 8'd10);
		get_special(8'd50, 8'd0, 8'd11);
		get_special(8'd2, 8'd0, 8'd19);
		get_special(8'd60, 8'd0, 8'd20);
		get_special(8'd1, 8'd0, 8'd4);
		get_special(8'd40, 8'd0, 8'd40);
		get_special(8'd5, 8'd1, 8'd10);
		idle();

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- mmix_dispatch.f
src/mmix_pkg.sv
src/stack_if.sv
src/op_class_decode.sv
src/operand_decode.sv
src/dest_rename.sv
src/stack_regs.sv
src/mmix_dispatch.sv
sim/tb_mmix_dispatch.sv

//--- run.sh
#!/bin/sh
# build and run the dispatch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mmix_dispatch \
	-f mmix_dispatch.f -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
	exit 0
fi
exit 1
